//--- src/ts_monitor_pkg.sv
`default_nettype none

package ts_monitor_pkg;

	localparam int pack_byte_size = 188;
	localparam int word_bytes = 4;
	localparam int pack_word_size = pack_byte_size / word_bytes;
	localparam logic [7:0] ts_sync_byte = 8'h47;
	localparam int pid_width = 13;
	localparam int data_width = 32;
	localparam int byte_idx_width = 8;
	localparam int word_addr_width = 6;

	// one byte of the transport stream with its sync flag
	typedef struct packed {
		logic [7:0] data;
		logic sync;
	} ts_byte_t;

	typedef struct packed {
		ts_byte_t d1;
		ts_byte_t d2;
		ts_byte_t d3;
	} pipe_taps_t;

	// one byte-lane write into a bank
	typedef struct packed {
		logic en;
		logic bank;
		logic [word_addr_width-1:0] word_addr;
		logic [1:0] lane;
		logic [7:0] data;
	} buf_wr_t;

	typedef struct packed {
		logic en;
		logic bank;
		logic [word_addr_width-1:0] word_addr;
	} buf_rd_t;

	typedef enum logic [1:0] {cap_idle, cap_fill, cap_full} cap_state_e;

	typedef enum logic [1:0] {rd_idle, rd_pump, rd_done} rd_state_e;

endpackage

`default_nettype wire

//--- src/ts_input_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module ts_input_pipe (
	input logic mpeg_clk,
	input logic S_AXI_ARESETN,
	input logic [7:0] mpeg_data,
	input logic mpeg_valid,
	input logic mpeg_sync,
	output ts_monitor_pkg::pipe_taps_t taps
);
	import ts_monitor_pkg::*;

	ts_byte_t in_byte;

	always_comb begin
		in_byte.data = mpeg_data;
		in_byte.sync = mpeg_sync;
	end

	// the line only moves on valid bytes, so gaps leave the taps untouched
	// d2 holds the sync byte while the second PID byte is still on the input
	always_ff @(posedge mpeg_clk) begin
		if (!S_AXI_ARESETN) begin
			taps <= '0;
		end else if (mpeg_valid) begin
			taps.d1 <= in_byte;
			taps.d2 <= taps.d1;
			taps.d3 <= taps.d2;
		end
	end

endmodule

`default_nettype wire

//--- src/pid_filter.sv
`timescale 1ns/1ps
`default_nettype none

module pid_filter (
	input logic mpeg_clk,
	input logic S_AXI_ARESETN,
	input logic [7:0] mpeg_data,
	input logic mpeg_valid,
	input ts_monitor_pkg::pipe_taps_t taps,
	input logic [ts_monitor_pkg::pid_width-1:0] pid,
	input logic pump_data_enable,
	output logic write_bank,
	output ts_monitor_pkg::buf_wr_t wr
);
	import ts_monitor_pkg::*;

	cap_state_e state;
	logic [byte_idx_width-1:0] byte_idx;
	logic header_seen;
	logic pid_hit;
	logic last_byte;

	// a header is a sync-flagged 8'h47 two bytes back
	assign header_seen = mpeg_valid && taps.d2.sync && (taps.d2.data == ts_sync_byte);

	// low bits of the first PID byte followed by the byte now on the input
	assign pid_hit = ({taps.d1.data[pid_width-9:0], mpeg_data} == pid);

	assign last_byte = (byte_idx == byte_idx_width'(pack_byte_size - 1));

	always_ff @(posedge mpeg_clk) begin
		if (!S_AXI_ARESETN) begin
			state <= cap_idle;
			byte_idx <= '0;
			write_bank <= 1'b0;
		end else if (header_seen) begin
			if (pid_hit) begin
				state <= cap_fill;
				byte_idx <= '0;
				// the bank under readout must stay put until the pump is released
				if (!pump_data_enable) begin
					write_bank <= ~write_bank;
				end
			end else begin
				state <= cap_idle;
			end
		end else begin
			case (state)
				cap_fill: begin
					if (mpeg_valid) begin
						if (last_byte) begin
							state <= cap_full;
						end else begin
							byte_idx <= byte_idx + 1'b1;
						end
					end
				end
				cap_idle, cap_full: begin
					byte_idx <= byte_idx;
				end
				default: begin
					state <= cap_idle;
				end
			endcase
		end
	end

	// d3 holds packet byte byte_idx while filling, and byte 0 goes to bits 7:0
	always_comb begin
		wr.en = mpeg_valid && (state == cap_fill);
		wr.bank = write_bank;
		wr.word_addr = word_addr_width'(byte_idx / word_bytes);
		wr.lane = 2'(byte_idx % word_bytes);
		wr.data = taps.d3.data;
	end

endmodule

`default_nettype wire

//--- src/packet_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module packet_buffer (
	input logic mpeg_clk,
	input logic S_AXI_ARESETN,
	input ts_monitor_pkg::buf_wr_t wr,
	input ts_monitor_pkg::buf_rd_t rd,
	output logic [ts_monitor_pkg::data_width-1:0] rd_word
);
	import ts_monitor_pkg::*;

	logic [data_width-1:0] bank0_mem [pack_word_size];
	logic [data_width-1:0] bank1_mem [pack_word_size];

	logic [word_bytes-1:0] bank0_we;
	logic [word_bytes-1:0] bank1_we;

	// one lane enable per byte, steered to the bank being filled
	always_comb begin
		bank0_we = '0;
		bank1_we = '0;
		if (wr.en) begin
			if (wr.bank) begin
				bank1_we[wr.lane] = 1'b1;
			end else begin
				bank0_we[wr.lane] = 1'b1;
			end
		end
	end

	always_ff @(posedge mpeg_clk) begin
		for (int l = 0; l < word_bytes; l++) begin
			if (bank0_we[l]) begin
				bank0_mem[wr.word_addr][8*l +: 8] <= wr.data;
			end
			if (bank1_we[l]) begin
				bank1_mem[wr.word_addr][8*l +: 8] <= wr.data;
			end
		end
	end

	// registered read, one edge behind the address
	always_ff @(posedge mpeg_clk) begin
		if (!S_AXI_ARESETN) begin
			rd_word <= '0;
		end else if (rd.en) begin
			if (rd.bank) begin
				rd_word <= bank1_mem[rd.word_addr];
			end else begin
				rd_word <= bank0_mem[rd.word_addr];
			end
		end
	end

endmodule

`default_nettype wire

//--- src/packet_readout.sv
`timescale 1ns/1ps
`default_nettype none

module packet_readout (
	input logic mpeg_clk,
	input logic S_AXI_ARESETN,
	input logic pump_data_enable,
	input logic write_bank,
	output ts_monitor_pkg::buf_rd_t rd,
	output logic [ts_monitor_pkg::data_width-1:0] out_data_index,
	output logic ready_for_read
);
	import ts_monitor_pkg::*;

	rd_state_e state;
	logic [word_addr_width-1:0] word_addr;
	logic read_bank;
	logic last_word;

	// readout always drains the bank that is not being filled
	assign read_bank = ~write_bank;
	assign last_word = (word_addr == word_addr_width'(pack_word_size - 1));

	always_comb begin
		rd.en = pump_data_enable && (state == rd_pump);
		rd.bank = read_bank;
		rd.word_addr = word_addr;
	end

	always_ff @(posedge mpeg_clk) begin
		if (!S_AXI_ARESETN) begin
			state <= rd_idle;
			word_addr <= '0;
			out_data_index <= '0;
			ready_for_read <= 1'b0;
		end else if (!pump_data_enable) begin
			state <= rd_idle;
			word_addr <= '0;
			ready_for_read <= 1'b0;
		end else begin
			case (state)
				rd_idle: begin
					state <= rd_pump;
					word_addr <= '0;
				end
				rd_pump: begin
					// the index lags the address by one edge, like the buffer word
					out_data_index <= {{(data_width - word_addr_width){1'b0}}, word_addr};
					if (last_word) begin
						state <= rd_done;
					end else begin
						word_addr <= word_addr + 1'b1;
					end
				end
				rd_done: begin
					ready_for_read <= 1'b1;
				end
				default: begin
					state <= rd_idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/ts_monitor_top.sv
`timescale 1ns/1ps
`default_nettype none

module ts_monitor_top (
	input logic mpeg_clk,
	input logic S_AXI_ARESETN,
	input logic [7:0] mpeg_data,
	input logic mpeg_valid,
	input logic mpeg_sync,
	input logic [ts_monitor_pkg::data_width-1:0] pid,
	input logic pump_data_enable,
	output logic [ts_monitor_pkg::data_width-1:0] out_data,
	output logic [ts_monitor_pkg::data_width-1:0] out_data_index,
	output logic ready_for_read
);
	import ts_monitor_pkg::*;

	pipe_taps_t taps;
	buf_wr_t wr;
	buf_rd_t rd;
	logic write_bank;

	ts_input_pipe u_input_pipe (
		.mpeg_clk(mpeg_clk),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.mpeg_data(mpeg_data),
		.mpeg_valid(mpeg_valid),
		.mpeg_sync(mpeg_sync),
		.taps(taps)
	);

	// only the low 13 bits of pid take part in the match
	pid_filter u_pid_filter (
		.mpeg_clk(mpeg_clk),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.mpeg_data(mpeg_data),
		.mpeg_valid(mpeg_valid),
		.taps(taps),
		.pid(pid[pid_width-1:0]),
		.pump_data_enable(pump_data_enable),
		.write_bank(write_bank),
		.wr(wr)
	);

	packet_buffer u_packet_buffer (
		.mpeg_clk(mpeg_clk),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.wr(wr),
		.rd(rd),
		.rd_word(out_data)
	);

	packet_readout u_packet_readout (
		.mpeg_clk(mpeg_clk),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.pump_data_enable(pump_data_enable),
		.write_bank(write_bank),
		.rd(rd),
		.out_data_index(out_data_index),
		.ready_for_read(ready_for_read)
	);

endmodule

`default_nettype wire

//--- testbench/ts_monitor_sva.sv
`timescale 1ns/1ps
`default_nettype none

module ts_monitor_sva (
	input logic mpeg_clk,
	input logic S_AXI_ARESETN,
	input logic pump_data_enable,
	input logic [ts_monitor_pkg::data_width-1:0] out_data_index,
	input logic ready_for_read
);
	import ts_monitor_pkg::*;

	int assert_failures = 0;

	release_clears_ready: assert property (@(posedge mpeg_clk) disable iff (!S_AXI_ARESETN)
		!pump_data_enable |=> !ready_for_read)
	else begin
		assert_failures++;
		$error("ready_for_read high in the cycle after pump_data_enable was released");
	end

	index_in_range: assert property (@(posedge mpeg_clk) disable iff (!S_AXI_ARESETN)
		out_data_index <= pack_word_size - 1)
	else begin
		assert_failures++;
		$error("out_data_index %0d is beyond the last word", out_data_index);
	end

	// ready must already be cleared by the first reset edge
	reset_clears_ready: assert property (@(posedge mpeg_clk)
		!S_AXI_ARESETN |=> !ready_for_read)
	else begin
		assert_failures++;
		$error("ready_for_read high while reset is applied");
	end

endmodule

bind ts_monitor_top ts_monitor_sva sva_checks (
	.mpeg_clk(mpeg_clk),
	.S_AXI_ARESETN(S_AXI_ARESETN),
	.pump_data_enable(pump_data_enable),
	.out_data_index(out_data_index),
	.ready_for_read(ready_for_read)
);

`default_nettype wire

//--- testbench/tb_ts_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ts_monitor;
	import ts_monitor_pkg::*;

	localparam int clk_period = 40;
	localparam int n_entries = 10;
	localparam int reset_cycles = 10;

	localparam logic [1:0] kind_normal = 2'd0;
	localparam logic [1:0] kind_false_sync = 2'd1;
	localparam logic [1:0] kind_truncated = 2'd2;

	localparam logic [1:0] ro_none = 2'd0;
	localparam logic [1:0] ro_after = 2'd1;
	localparam logic [1:0] ro_during = 2'd2;
	localparam logic [1:0] ro_abort = 2'd3;

	// exp_tag is the entry whose payload the readout returns, 8'hff when nothing is read
	typedef struct packed {
		logic [12:0] hdr_pid;
		logic [31:0] prog_pid;
		logic [1:0] kind;
		logic [1:0] gap_len;
		logic [1:0] ro_mode;
		logic [7:0] exp_tag;
	} entry_t;

	localparam entry_t test_table [n_entries] = '{
		'{13'h0abc, 32'h0000_0abc, kind_normal, 2'd0, ro_none, 8'hff},
		'{13'h0abc, 32'h0000_0abc, kind_normal, 2'd0, ro_after, 8'd0},
		'{13'h1abc, 32'h0000_0abc, kind_normal, 2'd0, ro_after, 8'd0},
		'{13'h0abc, 32'h5a5a_0abc, kind_normal, 2'd1, ro_none, 8'hff},
		'{13'h0abc, 32'h0000_0abc, kind_normal, 2'd0, ro_after, 8'd3},
		'{13'h0abc, 32'h0000_0abc, kind_normal, 2'd2, ro_during, 8'd3},
		'{13'h0abc, 32'h0000_0abc, kind_false_sync, 2'd0, ro_none, 8'hff},
		'{13'h0abc, 32'h0000_0abc, kind_truncated, 2'd0, ro_none, 8'hff},
		'{13'h0abc, 32'h0000_0abc, kind_normal, 2'd0, ro_after, 8'd5},
		'{13'h0abc, 32'h0000_0abc, kind_normal, 2'd0, ro_abort, 8'd8}
	};

	logic mpeg_clk;
	logic S_AXI_ARESETN;
	logic [7:0] mpeg_data;
	logic mpeg_valid;
	logic mpeg_sync;
	logic [31:0] pid;
	logic pump_data_enable;
	logic [31:0] out_data;
	logic [31:0] out_data_index;
	logic ready_for_read;

	logic [31:0] lfsr_state;
	logic [7:0] pkt [pack_byte_size];
	logic [7:0] model_mem [2][pack_byte_size];
	logic [7:0] model_tag [2];
	logic model_wbank;
	logic [31:0] exp_words [pack_word_size];
	logic stream_busy;

	ts_monitor_top UUT (
		.mpeg_clk(mpeg_clk),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.mpeg_data(mpeg_data),
		.mpeg_valid(mpeg_valid),
		.mpeg_sync(mpeg_sync),
		.pid(pid),
		.pump_data_enable(pump_data_enable),
		.out_data(out_data),
		.out_data_index(out_data_index),
		.ready_for_read(ready_for_read)
	);

	initial begin
		mpeg_clk = 1'b0;
		forever #(clk_period / 2) mpeg_clk = ~mpeg_clk;
	end

	// each entry gets one packet time plus a readout with some margin
	initial begin
		#(n_entries * (200 + 60) * clk_period);
		$display("timeout: stimulus did not complete within %0d cycles", n_entries * 260);
		$display("TEST FAILED");
		$fatal(1, "watchdog expired");
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 32'ha300_0000;
		end
		return n;
	endfunction

	function automatic logic [7:0] rand_bits(input int n_bits);
		logic [7:0] v;
		v = '0;
		for (int b = 0; b < n_bits; b++) begin
			v = {v[6:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
		return v;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("FAIL t=%0t %s expected %h actual %h", $time, name, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic step();
		@(posedge mpeg_clk);
		#2;
	endtask

	task automatic send_byte(input logic [7:0] data, input logic sync);
		mpeg_data = data;
		mpeg_sync = sync;
		mpeg_valid = 1'b1;
		step();
	endtask

	task automatic idle_cycle();
		mpeg_valid = 1'b0;
		mpeg_sync = 1'b0;
		mpeg_data = 8'h00;
		step();
	endtask

	task automatic build_packet(input entry_t e);
		pkt[0] = (e.kind == kind_false_sync) ? 8'h12 : ts_sync_byte;
		// flag bits above the PID are set so that the match must ignore them
		pkt[1] = {3'b010, e.hdr_pid[12:8]};
		pkt[2] = e.hdr_pid[7:0];
		for (int i = 3; i < pack_byte_size; i++) begin
			pkt[i] = rand_bits(8);
		end
	endtask

	task automatic apply_model(input entry_t e, input int idx);
		if (e.kind == kind_normal && e.hdr_pid == e.prog_pid[12:0]) begin
			// banks swap on a matching header only while readout is idle
			if (e.ro_mode != ro_during) begin
				model_wbank = ~model_wbank;
			end
			for (int i = 0; i < pack_byte_size; i++) begin
				model_mem[model_wbank][i] = pkt[i];
			end
			model_tag[model_wbank] = 8'(idx);
		end
	endtask

	task automatic load_expected();
		logic rb;
		rb = ~model_wbank;
		for (int k = 0; k < pack_word_size; k++) begin
			exp_words[k] = {model_mem[rb][4*k+3], model_mem[rb][4*k+2],
				model_mem[rb][4*k+1], model_mem[rb][4*k]};
		end
	endtask

	// trailing filler pushes the last bytes through the delay line
	task automatic send_packet(input entry_t e);
		int last;
		last = (e.kind == kind_truncated) ? 1 : pack_byte_size - 1;
		for (int i = 0; i <= last; i++) begin
			if (e.gap_len != 0 && i != 0 && rand_bits(3) == 8'd0) begin
				repeat (e.gap_len) idle_cycle();
			end
			send_byte(pkt[i], i == 0);
		end
		repeat (4) send_byte(8'hff, 1'b0);
		mpeg_valid = 1'b0;
	endtask

	task automatic read_words(input int n_words, input logic to_end);
		pump_data_enable = 1'b1;
		step();
		for (int k = 0; k < n_words; k++) begin
			step();
			check_value("out_data", exp_words[k], out_data);
			check_value("out_data_index", k, out_data_index);
			check_value("ready_for_read", 0, ready_for_read);
		end
		if (to_end) begin
			for (int h = 0; h < 4 || stream_busy; h++) begin
				step();
				check_value("ready_for_read", 1, ready_for_read);
				check_value("out_data_index", pack_word_size - 1, out_data_index);
				check_value("out_data", exp_words[pack_word_size - 1], out_data);
			end
		end
		pump_data_enable = 1'b0;
		step();
		check_value("ready_for_read", 0, ready_for_read);
	endtask

	initial begin
		entry_t e;
		mpeg_data = 8'h00;
		mpeg_valid = 1'b0;
		mpeg_sync = 1'b0;
		pid = '0;
		pump_data_enable = 1'b0;
		S_AXI_ARESETN = 1'b0;
		lfsr_state = 32'h72c0;
		model_wbank = 1'b0;
		model_tag[0] = 8'hff;
		model_tag[1] = 8'hff;
		stream_busy = 1'b0;
		repeat (reset_cycles) @(posedge mpeg_clk);
		#2;
		S_AXI_ARESETN = 1'b1;
		check_value("ready_for_read", 0, ready_for_read);
		check_value("out_data_index", 0, out_data_index);
		check_value("out_data", 0, out_data);
		for (int idx = 0; idx < n_entries; idx++) begin
			e = test_table[idx];
			pid = e.prog_pid;
			build_packet(e);
			apply_model(e, idx);
			load_expected();
			if (e.ro_mode != ro_none) begin
				check_value("read bank tag", e.exp_tag, model_tag[!model_wbank]);
			end
			case (e.ro_mode)
				ro_after: begin
					send_packet(e);
					read_words(pack_word_size, 1'b1);
				end
				ro_during: begin
					stream_busy = 1'b1;
					fork
						begin
							send_packet(e);
							stream_busy = 1'b0;
						end
						read_words(pack_word_size, 1'b1);
					join
				end
				ro_abort: begin
					send_packet(e);
					read_words(20, 1'b0);
					step();
					read_words(pack_word_size, 1'b1);
				end
				default: begin
					send_packet(e);
					check_value("ready_for_read", 0, ready_for_read);
				end
			endcase
		end
		if (UUT.sva_checks.assert_failures == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("%0d assertion failures were reported", UUT.sva_checks.assert_failures);
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
src/ts_monitor_pkg.sv
src/ts_input_pipe.sv
src/pid_filter.sv
src/packet_buffer.sv
src/packet_readout.sv
src/ts_monitor_top.sv
testbench/ts_monitor_sva.sv
testbench/tb_ts_monitor.sv

//--- Bender.yml
package:
  name: ts_monitor

sources:
  - src/ts_monitor_pkg.sv
  - src/ts_input_pipe.sv
  - src/pid_filter.sv
  - src/packet_buffer.sv
  - src/packet_readout.sv
  - src/ts_monitor_top.sv
  - target: test
    files:
      - testbench/ts_monitor_sva.sv
      - testbench/tb_ts_monitor.sv
